// File: tx_pkg.sv
//////////////////////////////////////////////////
// Shared types and register map of the transmit chain
// Scale is signed fixed point with 2 integer bits
//////////////////////////////////////////////////
`default_nettype none

package tx_pkg;

  // Channel counts
  localparam int CHANNELS         = 2;
  localparam int PARALLEL_SAMPLES = 2;
  // Ramp channels first, then triangle channels
  localparam int SRC_CHANNELS     = 2 * CHANNELS;
  localparam int SCALE_INT_BITS   = 2;

  typedef logic signed [15:0] sample_t;
  typedef logic        [31:0] phase_t;
  typedef logic signed [17:0] scale_t;
  typedef logic signed [13:0] offset_t;
  typedef logic        [1:0]  sel_t;

  // Write port types
  typedef logic [3:0]  cfg_addr_t;
  typedef logic [31:0] cfg_data_t;

  // Unity gain
  localparam scale_t SCALE_ONE = scale_t'(1) << ($bits(scale_t) - SCALE_INT_BITS);

  // One channel per clock, earlier sample in slot 0
  typedef struct packed {
    logic                                valid;
    sample_t [PARALLEL_SAMPLES-1:0]      samples;
  } bundle_t;

  typedef struct packed {
    phase_t  [CHANNELS-1:0]     ramp_inc;
    phase_t  [CHANNELS-1:0]     tri_inc;
    sel_t    [CHANNELS-1:0]     mux_sel;
    scale_t  [CHANNELS-1:0]     scale;
    offset_t [CHANNELS-1:0]     offset;
    logic    [SRC_CHANNELS-1:0] trig_mask;
    logic                       trig_oneshot;
  } tx_cfg_t;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////
  localparam cfg_addr_t ADDR_RAMP_INC0 = 4'h0;
  localparam cfg_addr_t ADDR_RAMP_INC1 = 4'h1;
  localparam cfg_addr_t ADDR_TRI_INC0  = 4'h2;
  localparam cfg_addr_t ADDR_TRI_INC1  = 4'h3;
  // Output 0 select in bits 1:0, output 1 in bits 3:2
  localparam cfg_addr_t ADDR_MUX_SEL   = 4'h4;
  localparam cfg_addr_t ADDR_SCALE0    = 4'h5;
  localparam cfg_addr_t ADDR_SCALE1    = 4'h6;
  localparam cfg_addr_t ADDR_OFFSET0   = 4'h7;
  localparam cfg_addr_t ADDR_OFFSET1   = 4'h8;
  // Mask in bits 3:0, one-shot in bit 4
  localparam cfg_addr_t ADDR_TRIG_CFG  = 4'h9;
  // Bit 0 clears phases, bit 1 re-arms the trigger
  localparam cfg_addr_t ADDR_CTRL      = 4'ha;

endpackage

`default_nettype wire

// File: tx_config_regs.sv
//////////////////////////////////////////////////
// Configuration registers behind a four-phase req/ack write port
// Write only, no readback; unknown addresses are acked and dropped
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tx_config_regs import tx_pkg::*; (
  input  logic      dac_clk,
  input  logic      rst_n,
  input  logic      cfg_req,
  input  cfg_addr_t cfg_addr,
  input  cfg_data_t cfg_wdata,
  output logic      cfg_ack,
  output tx_cfg_t   cfg,
  output logic      phase_clr,
  output logic      rearm
);

  logic wr_en;

  // New request while ack is still low
  assign wr_en = cfg_req && !cfg_ack;

  //////////////////////////////////////////////////
  // Handshake and control strobes
  //////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      cfg_ack   <= 1'b0;
      phase_clr <= 1'b0;
      rearm     <= 1'b0;
    end else begin
      // Ack up one cycle after req, down one cycle after req drops
      if (wr_en) begin
        cfg_ack <= 1'b1;
      end else if (!cfg_req) begin
        cfg_ack <= 1'b0;
      end
      // Single-cycle pulses, aligned with ack rising
      phase_clr <= wr_en && (cfg_addr == ADDR_CTRL) && cfg_wdata[0];
      rearm     <= wr_en && (cfg_addr == ADDR_CTRL) && cfg_wdata[1];
    end
  end

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      cfg       <= '0;
      cfg.scale <= {CHANNELS{SCALE_ONE}};
    end else if (wr_en) begin
      case (cfg_addr)
        ADDR_RAMP_INC0: cfg.ramp_inc[0] <= cfg_wdata;
        ADDR_RAMP_INC1: cfg.ramp_inc[1] <= cfg_wdata;
        ADDR_TRI_INC0:  cfg.tri_inc[0]  <= cfg_wdata;
        ADDR_TRI_INC1:  cfg.tri_inc[1]  <= cfg_wdata;
        ADDR_MUX_SEL:   cfg.mux_sel     <= cfg_wdata[$bits(sel_t)*CHANNELS-1:0];
        ADDR_SCALE0:    cfg.scale[0]    <= cfg_wdata[$bits(scale_t)-1:0];
        ADDR_SCALE1:    cfg.scale[1]    <= cfg_wdata[$bits(scale_t)-1:0];
        ADDR_OFFSET0:   cfg.offset[0]   <= cfg_wdata[$bits(offset_t)-1:0];
        ADDR_OFFSET1:   cfg.offset[1]   <= cfg_wdata[$bits(offset_t)-1:0];
        ADDR_TRIG_CFG: begin
          cfg.trig_mask    <= cfg_wdata[SRC_CHANNELS-1:0];
          cfg.trig_oneshot <= cfg_wdata[SRC_CHANNELS];
        end
        // CTRL only strobes; anything else is ignored
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tx_ramp_dds.sv
//////////////////////////////////////////////////
// Ramp DDS, no sine table, output is the phase MSBs
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tx_ramp_dds import tx_pkg::*; (
  input  logic                   dac_clk,
  input  logic                   rst_n,
  input  tx_cfg_t                cfg,
  input  logic                   phase_clr,
  output bundle_t [CHANNELS-1:0] data_out,
  output logic    [CHANNELS-1:0] trigger
);

  phase_t [CHANNELS-1:0] phase;
  phase_t [CHANNELS-1:0] phase_next;
  phase_t [CHANNELS-1:0] phase_mid;
  logic   [CHANNELS-1:0] carry;
  logic   [CHANNELS-1:0] wrap;
  logic                  valid_q;
  sample_t [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] samp_q;

  // Two samples per clock, so step by twice the increment
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      {carry[ch], phase_next[ch]} = {1'b0, phase[ch]} + {1'b0, phase_t'(cfg.ramp_inc[ch] << 1)};
      phase_mid[ch] = phase[ch] + cfg.ramp_inc[ch];
    end
  end

  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      phase   <= '0;
      wrap    <= '0;
      trigger <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      // Marks the first word after the wrap
      trigger <= wrap;
      if (phase_clr) begin
        phase <= '0;
        wrap  <= '0;
      end else begin
        phase <= phase_next;
        wrap  <= carry;
      end
    end
  end

  // Sawtooth straight from the phase MSBs
  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      samp_q[ch][0] <= phase[ch][$bits(phase_t)-1 -: $bits(sample_t)];
      samp_q[ch][1] <= phase_mid[ch][$bits(phase_t)-1 -: $bits(sample_t)];
    end
  end

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      data_out[ch].valid   = valid_q;
      data_out[ch].samples = samp_q[ch];
    end
  end

endmodule

`default_nettype wire

// File: tx_triangle_gen.sv
//////////////////////////////////////////////////
// Triangle generator, one period per phase wrap
// Zero increment after a clear holds the negative full scale
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tx_triangle_gen import tx_pkg::*; (
  input  logic                   dac_clk,
  input  logic                   rst_n,
  input  tx_cfg_t                cfg,
  input  logic                   phase_clr,
  output bundle_t [CHANNELS-1:0] data_out,
  output logic    [CHANNELS-1:0] trigger
);

  phase_t [CHANNELS-1:0] phase;
  phase_t [CHANNELS-1:0] phase_next;
  phase_t [CHANNELS-1:0] phase_mid;
  logic   [CHANNELS-1:0] carry;
  logic   [CHANNELS-1:0] wrap;
  logic                  valid_q;
  sample_t [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] samp_q;

  // Rising half while bit 31 is low, falling half after
  function automatic sample_t fold(input phase_t p);
    logic [$bits(sample_t)-1:0] mag;
    mag = p[$bits(phase_t)-2 -: $bits(sample_t)];
    if (!p[$bits(phase_t)-1]) begin
      fold = sample_t'(mag - 16'h8000);
    end else begin
      fold = sample_t'(16'h7fff - mag);
    end
  endfunction

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      {carry[ch], phase_next[ch]} = {1'b0, phase[ch]} + {1'b0, phase_t'(cfg.tri_inc[ch] << 1)};
      phase_mid[ch] = phase[ch] + cfg.tri_inc[ch];
    end
  end

  //////////////////////////////////////////////////
  // Phase accumulators
  //////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      phase   <= '0;
      wrap    <= '0;
      trigger <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      trigger <= wrap;
      if (phase_clr) begin
        phase <= '0;
        wrap  <= '0;
      end else begin
        phase <= phase_next;
        wrap  <= carry;
      end
    end
  end

  // Folded samples, one cycle behind the phase
  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      samp_q[ch][0] <= fold(phase[ch]);
      samp_q[ch][1] <= fold(phase_mid[ch]);
    end
  end

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      data_out[ch].valid   = valid_q;
      data_out[ch].samples = samp_q[ch];
    end
  end

endmodule

`default_nettype wire

// File: tx_channel_mux.sv
//////////////////////////////////////////////////
// Source select per output, one cycle of latency
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tx_channel_mux import tx_pkg::*; (
  input  logic                       dac_clk,
  input  logic                       rst_n,
  input  tx_cfg_t                    cfg,
  input  bundle_t [SRC_CHANNELS-1:0] data_in,
  output bundle_t [CHANNELS-1:0]     data_out
);

  logic [CHANNELS-1:0] valid_q;
  sample_t [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] samp_q;

  // Valid follows the chosen source
  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        valid_q[ch] <= data_in[cfg.mux_sel[ch]].valid;
      end
    end
  end

  // Sample payload
  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      samp_q[ch] <= data_in[cfg.mux_sel[ch]].samples;
    end
  end

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      data_out[ch].valid   = valid_q[ch];
      data_out[ch].samples = samp_q[ch];
    end
  end

endmodule

`default_nettype wire

// File: tx_affine.sv
//////////////////////////////////////////////////
// Scale, offset and saturate, two cycles of latency
// SCALE_FRAC_BITS must match the binary point of scale_t
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tx_affine import tx_pkg::*; #(
  parameter int SCALE_FRAC_BITS = 16
) (
  input  logic                   dac_clk,
  input  logic                   rst_n,
  input  tx_cfg_t                cfg,
  input  bundle_t [CHANNELS-1:0] data_in,
  output bundle_t [CHANNELS-1:0] data_out
);

  localparam int PROD_W  = $bits(sample_t) + $bits(scale_t);
  localparam int SUM_W   = PROD_W + 1;
  localparam int SAT_MAX = 2 ** ($bits(sample_t) - 1) - 1;
  localparam int SAT_MIN = -(2 ** ($bits(sample_t) - 1));

  logic [CHANNELS-1:0] valid_s1;
  logic [CHANNELS-1:0] valid_s2;
  logic signed [PROD_W-1:0] prod_q [CHANNELS][PARALLEL_SAMPLES];
  logic signed [SUM_W-1:0]  sum    [CHANNELS][PARALLEL_SAMPLES];
  sample_t [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] samp_q;

  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      valid_s1 <= '0;
      valid_s2 <= '0;
    end else begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        valid_s1[ch] <= data_in[ch].valid;
      end
      valid_s2 <= valid_s1;
    end
  end

  //////////////////////////////////////////////////
  // Stage 1, product back to sample scale
  //////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        prod_q[ch][s] <= ($signed(data_in[ch].samples[s]) * $signed(cfg.scale[ch]))
                         >>> SCALE_FRAC_BITS;
      end
    end
  end

  // Offset is sign-extended into the wider sum
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        sum[ch][s] = prod_q[ch][s] + $signed(cfg.offset[ch]);
      end
    end
  end

  // Stage 2, clamp to the DAC range
  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        if (sum[ch][s] > SAT_MAX) begin
          samp_q[ch][s] <= sample_t'(SAT_MAX);
        end else if (sum[ch][s] < SAT_MIN) begin
          samp_q[ch][s] <= sample_t'(SAT_MIN);
        end else begin
          samp_q[ch][s] <= sample_t'(sum[ch][s]);
        end
      end
    end
  end

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      data_out[ch].valid   = valid_s2[ch];
      data_out[ch].samples = samp_q[ch];
    end
  end

endmodule

`default_nettype wire

// File: tx_trigger_manager.sv
//////////////////////////////////////////////////
// Masked OR of the source triggers
// One-shot mode passes one trigger per arm
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tx_trigger_manager import tx_pkg::*; (
  input  logic                    dac_clk,
  input  logic                    rst_n,
  input  tx_cfg_t                 cfg,
  input  logic                    rearm,
  input  logic [SRC_CHANNELS-1:0] triggers_in,
  output logic                    trigger_out
);

  logic armed;
  logic hit;
  logic fire;

  // Any enabled source
  assign hit  = |(triggers_in & cfg.trig_mask);
  // Continuous mode ignores the armed flag
  assign fire = hit && (!cfg.trig_oneshot || armed);

  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      trigger_out <= 1'b0;
      armed       <= 1'b1;
    end else begin
      trigger_out <= fire;
      if (rearm) begin
        armed <= 1'b1;
      end else if (fire && cfg.trig_oneshot) begin
        armed <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: transmit_top.sv
//////////////////////////////////////////////////
// Transmit chain top, single DAC clock domain
// Config is written in dac_clk, no back-pressure from the DAC
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module transmit_top import tx_pkg::*; #(
  parameter int SCALE_FRAC_BITS = 16
) (
  input  logic                   dac_clk,
  input  logic                   rst_n,
  input  logic                   cfg_req,
  input  cfg_addr_t              cfg_addr,
  input  cfg_data_t              cfg_wdata,
  output logic                   cfg_ack,
  output bundle_t [CHANNELS-1:0] dac_data_out,
  output logic                   dac_trigger_out
);

  tx_cfg_t                    cfg;
  logic                       phase_clr;
  logic                       rearm;
  bundle_t [CHANNELS-1:0]     ramp_data;
  bundle_t [CHANNELS-1:0]     tri_data;
  bundle_t [SRC_CHANNELS-1:0] mux_in;
  bundle_t [CHANNELS-1:0]     mux_out;
  logic    [CHANNELS-1:0]     ramp_trig;
  logic    [CHANNELS-1:0]     tri_trig;
  logic    [SRC_CHANNELS-1:0] src_trig;

  //////////////////////////////////////////////////
  // Configuration
  //////////////////////////////////////////////////
  tx_config_regs i_config_regs (
    .dac_clk, .rst_n, .cfg_req, .cfg_addr, .cfg_wdata, .cfg_ack,
    .cfg, .phase_clr, .rearm
  );

  //////////////////////////////////////////////////
  // Signal chain
  //////////////////////////////////////////////////
  tx_ramp_dds i_ramp_dds (
    .dac_clk, .rst_n, .cfg, .phase_clr, .data_out(ramp_data), .trigger(ramp_trig)
  );

  tx_triangle_gen i_triangle_gen (
    .dac_clk, .rst_n, .cfg, .phase_clr, .data_out(tri_data), .trigger(tri_trig)
  );

  // Ramp sources in the low indices
  assign mux_in   = {tri_data, ramp_data};
  assign src_trig = {tri_trig, ramp_trig};

  tx_channel_mux i_channel_mux (
    .dac_clk, .rst_n, .cfg, .data_in(mux_in), .data_out(mux_out)
  );

  tx_affine #(
    .SCALE_FRAC_BITS(SCALE_FRAC_BITS)
  ) i_affine (
    .dac_clk, .rst_n, .cfg, .data_in(mux_out), .data_out(dac_data_out)
  );

  tx_trigger_manager i_trigger_manager (
    .dac_clk, .rst_n, .cfg, .rearm, .triggers_in(src_trig), .trigger_out(dac_trigger_out)
  );

endmodule

`default_nettype wire

// File: transmit_top_chk.sv
//////////////////////////////////////////////////
// Handshake and output rules, bound into transmit_top
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module transmit_top_chk import tx_pkg::*; (
  input logic                   dac_clk,
  input logic                   rst_n,
  input logic                   cfg_req,
  input logic                   cfg_ack,
  input bundle_t [CHANNELS-1:0] dac_data_out
);

  // Number of assertion failures so far
  int violations = 0;

  // Ack may only drop once req was seen low
  ack_after_req: assert property (@(posedge dac_clk) disable iff (!rst_n)
    $fell(cfg_ack) |-> !$past(cfg_req))
    else begin
      violations++;
      $error("cfg_ack fell while cfg_req was still high");
    end

  // Master keeps req up until ack answers
  req_held: assert property (@(posedge dac_clk) disable iff (!rst_n)
    cfg_req && !cfg_ack |=> cfg_req)
    else begin
      violations++;
      $error("cfg_req dropped before cfg_ack rose");
    end

  // No stall, so valid never drops after it rises
  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_valid
    valid_sticky: assert property (@(posedge dac_clk) disable iff (!rst_n)
      dac_data_out[ch].valid |=> dac_data_out[ch].valid)
      else begin
        violations++;
        $error("valid dropped on output %0d", ch);
      end
  end

endmodule

bind transmit_top transmit_top_chk i_chk (
  .dac_clk(dac_clk), .rst_n(rst_n), .cfg_req(cfg_req), .cfg_ack(cfg_ack),
  .dac_data_out(dac_data_out)
);

`default_nettype wire

// File: tb_transmit_top.sv
//////////////////////////////////////////////////
// Directed tests of the transmit chain
// Outputs sampled on the falling edge, inputs driven on the rising edge
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_transmit_top import tx_pkg::*; ;

  // Roughly 40 writes of 5 cycles plus 400 counted cycles, wide margin
  localparam int TIMEOUT_CYCLES = 6000;
  localparam int ACK_LIMIT      = 16;
  // Generator, mux and affine latency plus some slack
  localparam int SETTLE_CYCLES  = 8;
  // 1.0 with 16 fraction bits
  localparam int SCALE_UNITY    = 32'h0001_0000;

  logic                   dac_clk;
  logic                   rst_n;
  logic                   cfg_req;
  cfg_addr_t              cfg_addr;
  cfg_data_t              cfg_wdata;
  logic                   cfg_ack;
  bundle_t [CHANNELS-1:0] dac_data_out;
  logic                   dac_trigger_out;
  int                     cycle_count;
  int                     trig_count;

  transmit_top #(.SCALE_FRAC_BITS(16)) i_transmit_top (
    .dac_clk, .rst_n, .cfg_req, .cfg_addr, .cfg_wdata, .cfg_ack,
    .dac_data_out, .dac_trigger_out
  );

  initial begin
    dac_clk = 1'b0;
    forever #20 dac_clk = ~dac_clk;
  end

  // Watchdog
  always @(posedge dac_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, run exceeded %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  // Output trigger pulses seen so far
  always @(negedge dac_clk) begin
    if (rst_n && dac_trigger_out) begin
      trig_count <= trig_count + 1;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge dac_clk);
  endtask

  function automatic int slot_value(input int ch, input int s);
    sample_t v;
    v = dac_data_out[ch].samples[s];
    return int'(v);
  endfunction

  // Top 16 bits of a sum differ from the increment's by at most a carry
  function automatic bit step_close(input logic [15:0] diff, input logic [15:0] step);
    logic [15:0] err;
    err = diff - step;
    return (err == 16'h0000) || (err == 16'h0001) || (err == 16'hffff);
  endfunction

  // Four-phase write, bounded waits on both ack edges
  task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
    int waited;
    @(posedge dac_clk);
    cfg_req   <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    waited = 0;
    @(negedge dac_clk);
    while (!cfg_ack && waited < ACK_LIMIT) begin
      @(negedge dac_clk);
      waited++;
    end
    assert (cfg_ack) else begin
      $display("Write to address %0h was never acknowledged", addr);
      abort_run();
    end
    @(posedge dac_clk);
    cfg_req <= 1'b0;
    waited = 0;
    @(negedge dac_clk);
    while (cfg_ack && waited < ACK_LIMIT) begin
      @(negedge dac_clk);
      waited++;
    end
    assert (!cfg_ack) else begin
      $display("cfg_ack stayed high after the write to address %0h", addr);
      abort_run();
    end
  endtask

  // Both slots of several words on one output
  task automatic check_words(input int ch, input int exp);
    repeat (4) begin
      @(negedge dac_clk);
      check_equal($sformatf("dac_data_out[%0d].valid", ch), dac_data_out[ch].valid, 1);
      check_equal($sformatf("dac_data_out[%0d] slot 0", ch), slot_value(ch, 0), exp);
      check_equal($sformatf("dac_data_out[%0d] slot 1", ch), slot_value(ch, 1), exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic test_reset();
    for (int i = 0; i < 3; i++) begin
      @(posedge dac_clk);
      // Third edge still sees reset low, released right after it
      if (i == 2) begin
        rst_n <= 1'b1;
      end
      @(negedge dac_clk);
      check_equal("cfg_ack", cfg_ack, 0);
      check_equal("dac_data_out[0].valid", dac_data_out[0].valid, 0);
      check_equal("dac_data_out[1].valid", dac_data_out[1].valid, 0);
      check_equal("dac_trigger_out", dac_trigger_out, 0);
    end
  endtask

  task automatic test_ramp_step();
    phase_t      r;
    logic [15:0] step;
    logic [15:0] cur0;
    logic [15:0] cur1;
    logic [15:0] nxt0;
    r    = $urandom;
    step = r[31:16];
    write_reg(ADDR_RAMP_INC0, r);
    write_reg(ADDR_MUX_SEL, 32'h0);
    write_reg(ADDR_SCALE0, SCALE_UNITY);
    write_reg(ADDR_OFFSET0, 32'h0);
    wait_cycles(SETTLE_CYCLES);
    repeat (4) begin
      @(negedge dac_clk);
      check_equal("dac_data_out[0].valid", dac_data_out[0].valid, 1);
      cur0 = dac_data_out[0].samples[0];
      cur1 = dac_data_out[0].samples[1];
      @(negedge dac_clk);
      nxt0 = dac_data_out[0].samples[0];
      assert (step_close(cur1 - cur0, step)) else begin
        $display("Error at %0t: dac_data_out[0] in-word step = %0d, expected %0d",
                 $time, cur1 - cur0, step);
        abort_run();
      end
      assert (step_close(nxt0 - cur1, step)) else begin
        $display("Error at %0t: dac_data_out[0] word-to-word step = %0d, expected %0d",
                 $time, nxt0 - cur1, step);
        abort_run();
      end
    end
  endtask

  task automatic test_triangle_mux();
    write_reg(ADDR_TRI_INC0, 32'h0);
    write_reg(ADDR_CTRL, 32'h1);
    // Output 0 from triangle channel 0
    write_reg(ADDR_MUX_SEL, 32'h2);
    wait_cycles(SETTLE_CYCLES);
    check_words(0, -32768);
  endtask

  task automatic test_affine();
    int o0;
    int o1;
    int big_scale;
    o0 = int'($urandom % 16384) - 8192;
    o1 = int'($urandom % 16384) - 8192;
    // Ramp 0 frozen at phase zero feeds both outputs
    write_reg(ADDR_RAMP_INC0, 32'h0);
    write_reg(ADDR_CTRL, 32'h1);
    write_reg(ADDR_MUX_SEL, 32'h0);
    write_reg(ADDR_OFFSET0, o0);
    write_reg(ADDR_OFFSET1, o1);
    wait_cycles(SETTLE_CYCLES);
    check_words(0, o0);
    check_words(1, o1);
    // Triangle sources at -32768, half scale
    write_reg(ADDR_MUX_SEL, 32'he);
    write_reg(ADDR_SCALE0, 32'h0000_8000);
    write_reg(ADDR_SCALE1, 32'h0000_8000);
    wait_cycles(SETTLE_CYCLES);
    check_words(0, -16384 + o0);
    check_words(1, -16384 + o1);
    // Near +2.0 drives low, -2.0 drives high
    big_scale = 100000 + int'($urandom % 31000);
    write_reg(ADDR_SCALE0, big_scale);
    write_reg(ADDR_OFFSET0, -8192);
    write_reg(ADDR_SCALE1, 32'h0002_0000);
    write_reg(ADDR_OFFSET1, 8191);
    wait_cycles(SETTLE_CYCLES);
    check_words(0, -32768);
    check_words(1, 32767);
  endtask

  task automatic test_triggers();
    int base;
    int pulses;
    // Wrap every 8 cycles on ramp 0
    write_reg(ADDR_RAMP_INC0, 32'h1000_0000);
    write_reg(ADDR_TRIG_CFG, 32'h01);
    base = trig_count;
    wait_cycles(80);
    pulses = trig_count - base;
    assert (pulses >= 9 && pulses <= 11) else begin
      $display("Error at %0t: dac_trigger_out pulses = %0d, expected 10 within 1",
               $time, pulses);
      abort_run();
    end
    write_reg(ADDR_TRIG_CFG, 32'h00);
    base = trig_count;
    wait_cycles(80);
    check_equal("dac_trigger_out pulses, masked", trig_count - base, 0);
    // One-shot, armed with the mask still closed
    write_reg(ADDR_TRIG_CFG, 32'h10);
    write_reg(ADDR_CTRL, 32'h2);
    base = trig_count;
    write_reg(ADDR_TRIG_CFG, 32'h11);
    wait_cycles(80);
    check_equal("dac_trigger_out pulses, one-shot", trig_count - base, 1);
    base = trig_count;
    write_reg(ADDR_CTRL, 32'h2);
    wait_cycles(80);
    check_equal("dac_trigger_out pulses, re-armed", trig_count - base, 1);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    rst_n       = 1'b0;
    cfg_req     = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    cycle_count = 0;
    trig_count  = 0;
    void'($urandom(32'hb332));
    test_reset();
    test_ramp_step();
    test_triangle_mux();
    test_affine();
    test_triggers();
    wait_cycles(4);
    if (i_transmit_top.i_chk.violations == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", i_transmit_top.i_chk.violations);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: transmit_top.f
tx_pkg.sv
tx_config_regs.sv
tx_ramp_dds.sv
tx_triangle_gen.sv
tx_channel_mux.sv
tx_affine.sv
tx_trigger_manager.sv
transmit_top.sv
transmit_top_chk.sv
tb_transmit_top.sv

// File: Bender.yml
package:
  name: transmit_top

sources:
  - tx_pkg.sv
  - tx_config_regs.sv
  - tx_ramp_dds.sv
  - tx_triangle_gen.sv
  - tx_channel_mux.sv
  - tx_affine.sv
  - tx_trigger_manager.sv
  - transmit_top.sv
  - target: test
    files:
      - transmit_top_chk.sv
      - tb_transmit_top.sv
